/* files.f */
design/mem_pkg.sv
design/afi_pkg.sv
design/phy_reset_sync.sv
design/addr_cmd_path.sv
design/write_path.sv
design/read_path.sv
design/memphy.sv
test/tb_memphy.sv

/* test/tb_memphy.sv */
// Directed testbench for memphy
// Inputs change 2 ns after the rising edge, outputs are checked at the same point
// The testbench plays the memory and drives mem_rdata from a pattern of the cycle count
// Expected streams are rebuilt from a per-cycle history of the driven inputs
`timescale 1ns/100ps

module tb_memphy
	import mem_pkg::*, afi_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 2000;
	localparam int HIST_DEPTH     = 256;
	localparam int DRAIN_CYCLES   = 20;

	logic                      pll_afi_clk;
	logic                      rst_n;
	logic                      soft_reset_n;
	logic                      pll_locked;
	afi_cmd_t                  afi_cmd;
	afi_wr_t                   afi_wr;
	logic                      afi_rdata_en;
	logic [WR_SHIFT_WIDTH-1:0] wr_shift;
	logic [RD_LAT_WIDTH-1:0]   read_latency;
	logic [AFI_DATA_WIDTH-1:0] mem_rdata;
	logic                      ctl_reset_n;
	mem_cmd_t                  mem_cmd;
	mem_wr_t                   mem_wr;
	logic [AFI_DATA_WIDTH-1:0] afi_rdata;
	logic                      afi_rdata_valid;

	int                        cycle;
	int                        checks;
	int                        errors;
	int unsigned               seed_ret;
	afi_cmd_t                  cmd_hist [HIST_DEPTH];
	afi_wr_t                   wr_hist [HIST_DEPTH];
	logic                      en_hist [HIST_DEPTH];
	logic [AFI_DATA_WIDTH-1:0] rd_expect_q [$];

	memphy i_dut (
		.pll_afi_clk     (pll_afi_clk),
		.rst_n           (rst_n),
		.soft_reset_n    (soft_reset_n),
		.pll_locked      (pll_locked),
		.afi_cmd         (afi_cmd),
		.afi_wr          (afi_wr),
		.afi_rdata_en    (afi_rdata_en),
		.wr_shift        (wr_shift),
		.read_latency    (read_latency),
		.mem_rdata       (mem_rdata),
		.ctl_reset_n     (ctl_reset_n),
		.mem_cmd         (mem_cmd),
		.mem_wr          (mem_wr),
		.afi_rdata       (afi_rdata),
		.afi_rdata_valid (afi_rdata_valid)
	);

	initial
	begin
		pll_afi_clk = 1'b0;
		forever #20 pll_afi_clk = ~pll_afi_clk;
	end

	// Cycle counter and run limit
	initial
	begin
		cycle = 0;
		while (cycle < TIMEOUT_CYCLES)
		begin
			@(posedge pll_afi_clk);
			cycle++;
		end
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("sim failed");
		$finish;
	end

	// Memory read data, mixes every bit of the cycle count
	function automatic logic [AFI_DATA_WIDTH-1:0] rdata_pattern(input int c);
		logic [31:0] h;
		h = c * 32'h9e3779b1;
		return h[31:16] ^ h[15:0];
	endfunction

	task automatic report_mismatch(input string msg);
		errors++;
		$display("mismatch at %0t ns: %s", $time, msg);
	endtask

	// Advance to the drive point of the next cycle and present new read data
	task automatic wait_drive_point();
		@(posedge pll_afi_clk);
		#2;
		mem_rdata = rdata_pattern(cycle);
	endtask

	task automatic drive_idle();
		afi_cmd.addr            = '0;
		afi_cmd.cke             = '1;
		afi_cmd.cs_n            = '1;
		afi_cmd.mem_clk_disable = 1'b0;
		afi_wr                  = '0;
		afi_rdata_en            = 1'b0;
	endtask

	task automatic record_inputs(input int j);
		cmd_hist[j] = afi_cmd;
		wr_hist[j]  = afi_wr;
		en_hist[j]  = afi_rdata_en;
		if (afi_rdata_en)
			rd_expect_q.push_back(rdata_pattern(cycle + int'(read_latency)));
	endtask

	// Check all three output streams against the inputs recorded j calls back
	task automatic compare_outputs(input int j);
		int                        off_c;
		int                        off_w;
		int                        off_r;
		mem_cmd_t                  exp_cmd;
		mem_wr_t                   exp_wr;
		logic                      exp_valid;
		logic [AFI_DATA_WIDTH-1:0] exp_data;
		off_c = 1 + AC_LATENCY;
		off_w = 2 + int'(wr_shift);
		off_r = 2 + int'(read_latency);
		if (j >= off_c)
		begin
			exp_cmd.ca    = cmd_hist[j-off_c].addr[MEM_CA_WIDTH-1:0];
			exp_cmd.cke   = cmd_hist[j-off_c].cke;
			exp_cmd.cs_n  = cmd_hist[j-off_c].cs_n;
			exp_cmd.ck_en = ~cmd_hist[j-off_c].mem_clk_disable;
			checks++;
			if (mem_cmd !== exp_cmd)
				report_mismatch($sformatf("mem_cmd %h, expected %h", mem_cmd, exp_cmd));
		end
		if (j >= off_w)
		begin
			exp_wr.oe = wr_hist[j-off_w].wdata_valid;
			exp_wr.dq = exp_wr.oe ? wr_hist[j-off_w].wdata : '0;
			exp_wr.dm = exp_wr.oe ? wr_hist[j-off_w].dm : '0;
			checks++;
			if (mem_wr !== exp_wr)
				report_mismatch($sformatf("mem_wr %h, expected %h", mem_wr, exp_wr));
		end
		if (j >= off_r)
			exp_valid = en_hist[j-off_r];
		else
			exp_valid = 1'b0;
		checks++;
		if (afi_rdata_valid !== exp_valid)
			report_mismatch($sformatf("afi_rdata_valid %b, expected %b",
				afi_rdata_valid, exp_valid));
		if (afi_rdata_valid === 1'b1)
		begin
			if (rd_expect_q.size() == 0)
			begin
				errors++;
				$display("error: read data returned with no read outstanding");
			end
			else
			begin
				exp_data = rd_expect_q.pop_front();
				checks++;
				if (afi_rdata !== exp_data)
					report_mismatch($sformatf("afi_rdata %h, expected %h", afi_rdata, exp_data));
			end
		end
	endtask

	// Idle cycles until every stream has drained, then account for all reads
	task automatic run_idle(input int first, input int count);
		for (int j = first; j < first + count; j++)
		begin
			wait_drive_point();
			compare_outputs(j);
			drive_idle();
			record_inputs(j);
		end
		if (rd_expect_q.size() != 0)
		begin
			errors++;
			$display("error: %0d reads never returned valid data", rd_expect_q.size());
		end
		rd_expect_q.delete();
	endtask

	task automatic verify_reset_outputs(input string when);
		checks++;
		if (ctl_reset_n !== 1'b0 || mem_cmd.cs_n !== '1 || mem_cmd.cke !== '0 ||
			mem_cmd.ck_en !== 1'b0 || mem_wr.oe !== 1'b0 || afi_rdata_valid !== 1'b0)
			report_mismatch({"outputs not in reset state ", when});
	endtask

	// ctl_reset_n must rise on the third edge after the source clears
	task automatic expect_release(input string src);
		for (int k = 1; k <= 3; k++)
		begin
			wait_drive_point();
			checks++;
			if (ctl_reset_n !== (k == 3))
				report_mismatch($sformatf("ctl_reset_n %b at edge %0d after %s release",
					ctl_reset_n, k, src));
		end
	endtask

	task automatic reset_test();
		repeat (2)
		begin
			wait_drive_point();
			verify_reset_outputs("after power-up");
		end
		rst_n = 1'b1;
		expect_release("rst_n");
		wait_drive_point();
		soft_reset_n = 1'b0;
		#1;
		verify_reset_outputs("during soft reset");
		wait_drive_point();
		soft_reset_n = 1'b1;
		expect_release("soft_reset_n");
		wait_drive_point();
		pll_locked = 1'b0;
		#1;
		verify_reset_outputs("while PLL unlocked");
		wait_drive_point();
		pll_locked = 1'b1;
		expect_release("pll_locked");
	endtask

	task automatic command_test();
		logic [31:0] rnd;
		for (int j = 0; j < 40; j++)
		begin
			wait_drive_point();
			compare_outputs(j);
			rnd     = $urandom;
			afi_cmd = rnd[$bits(afi_cmd_t)-1:0];
			record_inputs(j);
		end
		run_idle(40, DRAIN_CYCLES);
	endtask

	// Bursts of four valid words separated by two-cycle gaps
	task automatic write_test(input logic [WR_SHIFT_WIDTH-1:0] shift);
		logic [31:0] rnd;
		wr_shift = shift;
		for (int j = 0; j < 30; j++)
		begin
			wait_drive_point();
			compare_outputs(j);
			rnd                = $urandom;
			afi_wr             = rnd[$bits(afi_wr_t)-1:0];
			afi_wr.wdata_valid = (j % 6) < 4;
			record_inputs(j);
		end
		run_idle(30, DRAIN_CYCLES);
	endtask

	// Back-to-back enables first, spaced ones after
	task automatic read_test(input logic [RD_LAT_WIDTH-1:0] latency);
		read_latency = latency;
		for (int j = 0; j < 30; j++)
		begin
			wait_drive_point();
			compare_outputs(j);
			afi_rdata_en = (j < 5) || (j % 4 == 1);
			record_inputs(j);
		end
		run_idle(30, DRAIN_CYCLES);
	endtask

	task automatic mixed_traffic_test();
		logic [31:0] rnd;
		wr_shift     = 2'd2;
		read_latency = 4'd6;
		for (int j = 0; j < 200; j++)
		begin
			wait_drive_point();
			compare_outputs(j);
			rnd          = $urandom;
			afi_cmd      = rnd[$bits(afi_cmd_t)-1:0];
			rnd          = $urandom;
			afi_wr       = rnd[$bits(afi_wr_t)-1:0];
			afi_rdata_en = rnd[31];
			record_inputs(j);
		end
		run_idle(200, DRAIN_CYCLES);
	endtask

	initial
	begin
		seed_ret     = $urandom(32'h52e11c4f);
		checks       = 0;
		errors       = 0;
		rst_n        = 1'b0;
		soft_reset_n = 1'b1;
		pll_locked   = 1'b1;
		wr_shift     = '0;
		read_latency = 4'd4;
		mem_rdata    = '0;
		drive_idle();
		reset_test();
		command_test();
		write_test(2'd0);
		write_test(2'd3);
		read_test(4'd4);
		read_test(4'd15);
		mixed_traffic_test();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* design/memphy.sv */
// Controller-facing core of the LPDDR2 PHY, single pll_afi_clk domain
// Memory side is presented at AFI width since pads, DDIO and DLL are absent
// ctl_reset_n is the conditioned PHY reset and also resets every datapath
// wr_shift and read_latency come from calibration and are held static
`timescale 1ns/100ps

module memphy
	import mem_pkg::*, afi_pkg::*;
(
	input  logic                      pll_afi_clk,
	input  logic                      rst_n,
	input  logic                      soft_reset_n,
	input  logic                      pll_locked,
	input  afi_cmd_t                  afi_cmd,
	input  afi_wr_t                   afi_wr,
	input  logic                      afi_rdata_en,
	input  logic [WR_SHIFT_WIDTH-1:0] wr_shift,
	input  logic [RD_LAT_WIDTH-1:0]   read_latency,
	input  logic [AFI_DATA_WIDTH-1:0] mem_rdata,
	output logic                      ctl_reset_n,
	output mem_cmd_t                  mem_cmd,
	output mem_wr_t                   mem_wr,
	output logic [AFI_DATA_WIDTH-1:0] afi_rdata,
	output logic                      afi_rdata_valid
);

	logic phy_rst_n;

	phy_reset_sync i_reset (
		.pll_afi_clk  (pll_afi_clk),
		.rst_n        (rst_n),
		.soft_reset_n (soft_reset_n),
		.pll_locked   (pll_locked),
		.phy_rst_n    (phy_rst_n)
	);

	assign ctl_reset_n = phy_rst_n;

	addr_cmd_path i_addr_cmd (
		.pll_afi_clk (pll_afi_clk),
		.rst_n       (phy_rst_n),
		.afi_cmd     (afi_cmd),
		.mem_cmd     (mem_cmd)
	);

	write_path i_write (
		.pll_afi_clk (pll_afi_clk),
		.rst_n       (phy_rst_n),
		.afi_wr      (afi_wr),
		.wr_shift    (wr_shift),
		.mem_wr      (mem_wr)
	);

	read_path i_read (
		.pll_afi_clk     (pll_afi_clk),
		.rst_n           (phy_rst_n),
		.afi_rdata_en    (afi_rdata_en),
		.read_latency    (read_latency),
		.mem_rdata       (mem_rdata),
		.afi_rdata       (afi_rdata),
		.afi_rdata_valid (afi_rdata_valid)
	);

endmodule

/* design/read_path.sv */
// Read valid prediction and read data capture
// An enable captured on edge N samples mem_rdata on edge N+read_latency;
// that word is presented with afi_rdata_valid on edge N+read_latency+1
// read_latency must lie in RD_LAT_MIN..RD_LAT_MAX and stay static while
// reads are in flight
// afi_rdata holds its last value while valid is low
`timescale 1ns/100ps

module read_path
	import afi_pkg::*;
(
	input  logic                      pll_afi_clk,
	input  logic                      rst_n,
	input  logic                      afi_rdata_en,
	input  logic [RD_LAT_WIDTH-1:0]   read_latency,
	input  logic [AFI_DATA_WIDTH-1:0] mem_rdata,
	output logic [AFI_DATA_WIDTH-1:0] afi_rdata,
	output logic                      afi_rdata_valid
);

	logic [RD_LAT_MAX-1:0]     vld_line;
	logic [RD_LAT_WIDTH-1:0]   tap_sel;
	logic                      cap_en;
	logic                      cap_valid;
	logic [AFI_DATA_WIDTH-1:0] cap_data;

	// Entry k holds an enable captured k+1 edges ago
	assign tap_sel = read_latency - 1'b1;
	assign cap_en  = vld_line[tap_sel];

	always_ff @(posedge pll_afi_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			vld_line        <= '0;
			cap_valid       <= 1'b0;
			afi_rdata_valid <= 1'b0;
		end
		else
		begin
			vld_line        <= {vld_line[RD_LAT_MAX-2:0], afi_rdata_en};
			cap_valid       <= cap_en;
			afi_rdata_valid <= cap_valid;
		end
	end

	// Capture register on the predicted edge
	always_ff @(posedge pll_afi_clk)
	begin
		if (cap_en)
			cap_data <= mem_rdata;
	end

	// Return stage toward the controller
	always_ff @(posedge pll_afi_clk)
	begin
		if (cap_valid)
			afi_rdata <= cap_data;
	end

	// Latencies below the minimum are not calibrated values
	a_rd_lat_min: assert property (@(posedge pll_afi_clk) disable iff (!rst_n)
		afi_rdata_en |-> read_latency >= RD_LAT_MIN);

endmodule

/* design/write_path.sv */
// Write datapath with a calibrated whole-cycle shift
// afi_wr captured on edge N reaches mem_wr on edge N+1+wr_shift
// wr_shift is a static calibration value and must not move while
// write data is in the shift line
// dq and dm are forced to zero whenever oe is low
`timescale 1ns/100ps

module write_path
	import mem_pkg::*, afi_pkg::*;
(
	input  logic                      pll_afi_clk,
	input  logic                      rst_n,
	input  afi_wr_t                   afi_wr,
	input  logic [WR_SHIFT_WIDTH-1:0] wr_shift,
	output mem_wr_t                   mem_wr
);

	afi_wr_t                   wr_line [WR_SHIFT_DEPTH];
	afi_wr_t                   wr_sel;
	logic [WR_SHIFT_DEPTH-1:0] line_valid;

	// Shift line, one entry per cycle of delay
	always_ff @(posedge pll_afi_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < WR_SHIFT_DEPTH; i++)
				wr_line[i] <= '0;
		end
		else
		begin
			wr_line[0] <= afi_wr;
			for (int i = 1; i < WR_SHIFT_DEPTH; i++)
				wr_line[i] <= wr_line[i-1];
		end
	end

	always_comb
	begin
		wr_sel = wr_line[wr_shift];
		for (int i = 0; i < WR_SHIFT_DEPTH; i++)
			line_valid[i] = wr_line[i].wdata_valid;
	end

	// Output stage toward the pins
	always_ff @(posedge pll_afi_clk or negedge rst_n)
	begin
		if (!rst_n)
			mem_wr <= '0;
		else
		begin
			mem_wr.oe <= wr_sel.wdata_valid;
			if (wr_sel.wdata_valid)
			begin
				mem_wr.dq <= wr_sel.wdata;
				mem_wr.dm <= wr_sel.dm;
			end
			else
			begin
				mem_wr.dq <= '0;
				mem_wr.dm <= '0;
			end
		end
	end

	// Changing the shift with data in flight would drop or repeat words
	a_shift_stable: assert property (@(posedge pll_afi_clk) disable iff (!rst_n)
		(|line_valid) |-> $stable(wr_shift));

endmodule

/* design/addr_cmd_path.sv */
// Address/command pipeline from AFI to the memory command pins
// afi_cmd is captured on edge N and mem_cmd updates on edge N+AC_LATENCY
// Only the lower CA word of addr is forwarded, the upper one belonged to the DDIO
// In reset the bus is deselected, powered down and the memory clock is off
`timescale 1ns/100ps

module addr_cmd_path
	import mem_pkg::*, afi_pkg::*;
(
	input  logic     pll_afi_clk,
	input  logic     rst_n,
	input  afi_cmd_t afi_cmd,
	output mem_cmd_t mem_cmd
);

	mem_cmd_t cmd_in;
	mem_cmd_t cmd_q;
	mem_cmd_t pipe [AC_LATENCY];

	// Map AFI fields onto the memory command layout
	always_comb
	begin
		cmd_in.ca    = afi_cmd.addr[MEM_CA_WIDTH-1:0];
		cmd_in.cke   = afi_cmd.cke;
		cmd_in.cs_n  = afi_cmd.cs_n;
		cmd_in.ck_en = ~afi_cmd.mem_clk_disable;
	end

	// Capture register then AC_LATENCY pipeline stages
	always_ff @(posedge pll_afi_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cmd_q <= MEM_CMD_IDLE;
			for (int i = 0; i < AC_LATENCY; i++)
				pipe[i] <= MEM_CMD_IDLE;
		end
		else
		begin
			cmd_q   <= cmd_in;
			pipe[0] <= cmd_q;
			for (int i = 1; i < AC_LATENCY; i++)
				pipe[i] <= pipe[i-1];
		end
	end

	assign mem_cmd = pipe[AC_LATENCY-1];

	// cke must never float toward the device once the PHY is running
	a_cke_known: assert property (@(posedge pll_afi_clk) disable iff (!rst_n)
		!$isunknown(mem_cmd.cke));

endmodule

/* design/phy_reset_sync.sv */
// PHY reset conditioner for the pll_afi_clk domain
// Any of rst_n, soft_reset_n or pll_locked going low clears the chain at once
// Release is synchronous, RESET_SYNC_STAGES edges after all three are high
// pll_locked is treated as a level; glitches on it will reset the PHY
`timescale 1ns/100ps

module phy_reset_sync
	import afi_pkg::*;
(
	input  logic pll_afi_clk,
	input  logic rst_n,
	input  logic soft_reset_n,
	input  logic pll_locked,
	output logic phy_rst_n
);

	logic                         clr_n;
	logic [RESET_SYNC_STAGES-1:0] sync_q;

	// Combined asynchronous clear
	assign clr_n = rst_n & soft_reset_n & pll_locked;

	always_ff @(posedge pll_afi_clk or negedge clr_n)
	begin
		if (!clr_n)
			sync_q <= '0;
		else
			sync_q <= {sync_q[RESET_SYNC_STAGES-2:0], 1'b1};
	end

	assign phy_rst_n = sync_q[RESET_SYNC_STAGES-1];

	// PHY must not leave reset without a locked PLL
	a_no_release_unlocked: assert property (@(posedge pll_afi_clk)
		$rose(phy_rst_n) |-> pll_locked);

endmodule

/* design/afi_pkg.sv */
// Controller-side (AFI) widths, latency limits and bus structs
// Full-rate AFI: one AFI word per pll_afi_clk cycle, two memory beats
// addr holds two CA words; only the lower one reaches the pins
// read_latency must stay within RD_LAT_MIN..RD_LAT_MAX
package afi_pkg;
	import mem_pkg::*;

	localparam int AFI_DATA_WIDTH = MEM_BEATS * MEM_DQ_WIDTH;
	localparam int AFI_DM_WIDTH   = MEM_BEATS * MEM_DM_WIDTH;
	localparam int AFI_ADDR_WIDTH = MEM_BEATS * MEM_CA_WIDTH;

	// Edges from the edge that samples afi_cmd to the mem_cmd update
	localparam int AC_LATENCY = 2;

	// Write shift of 0 to 3 whole cycles
	localparam int WR_SHIFT_WIDTH = 2;
	localparam int WR_SHIFT_DEPTH = 1 << WR_SHIFT_WIDTH;

	localparam int RD_LAT_WIDTH = 4;
	localparam int RD_LAT_MIN   = 2;
	localparam int RD_LAT_MAX   = 15;

	localparam int RESET_SYNC_STAGES = 3;

	typedef struct packed {
		logic [AFI_ADDR_WIDTH-1:0] addr;
		logic [MEM_CKE_WIDTH-1:0]  cke;
		logic [MEM_CS_WIDTH-1:0]   cs_n;
		logic                      mem_clk_disable;
	} afi_cmd_t;

	typedef struct packed {
		logic [AFI_DATA_WIDTH-1:0] wdata;
		logic [AFI_DM_WIDTH-1:0]   dm;
		logic                      wdata_valid;
	} afi_wr_t;

endpackage

/* design/mem_pkg.sv */
// Memory-side widths and bus structs for the LPDDR2 PHY core
// The DDIO cells are not modeled, so each dq/dm word on the memory side
// carries both beats of one AFI word side by side
// MEM_CMD_IDLE is the command bus value while the PHY is in reset
package mem_pkg;

	// Data beats per AFI clock cycle
	localparam int MEM_BEATS = 2;

	localparam int MEM_DQ_WIDTH  = 8;
	localparam int MEM_DM_WIDTH  = 1;
	localparam int MEM_CA_WIDTH  = 10;
	localparam int MEM_CS_WIDTH  = 1;
	localparam int MEM_CKE_WIDTH = 1;

	typedef struct packed {
		logic [MEM_CA_WIDTH-1:0]  ca;
		logic [MEM_CKE_WIDTH-1:0] cke;
		logic [MEM_CS_WIDTH-1:0]  cs_n;
		logic                     ck_en;
	} mem_cmd_t;

	typedef struct packed {
		logic [MEM_BEATS*MEM_DQ_WIDTH-1:0] dq;
		logic [MEM_BEATS*MEM_DM_WIDTH-1:0] dm;
		logic                              oe;
	} mem_wr_t;

	// Deselected and powered down, memory clock stopped
	localparam mem_cmd_t MEM_CMD_IDLE = '{ca: '0, cke: '0, cs_n: '1, ck_en: 1'b0};

endpackage
